// ==== filelist.f ====
+incdir+include
verilog/periph_bus_pkg.sv
verilog/wb_master.sv
verilog/wb_decoder.sv
verilog/wb_slave.sv
verilog/periph_bus.sv
sim/tb_clock_gen.sv
sim/tb_device_model.sv
sim/periph_bus_tb.sv

// ==== include/periph_bus_config.svh ====
// Width, slot-field and slot-code macros for the peripheral bus.
`ifndef PERIPH_BUS_CONFIG_SVH
`define PERIPH_BUS_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Bus widths
// ~~~~~~~~~~~~~~~~~~~~
`define PB_ADDR_W    32
`define PB_DATA_W    32
`define PB_MASK_W    4

// ~~~~~~~~~~~~~~~~~~~~
// Address map
// ~~~~~~~~~~~~~~~~~~~~
// Slot field sits at addr[13:12].
`define PB_SLOT_LSB  12
`define PB_SLOT_W    2

`define PB_SLOT_UART 0
`define PB_SLOT_SPI  1
`define PB_SLOT_PWM  2
`define PB_SLOT_NONE 3

`endif

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module periph_bus_tb \
    -o periph_bus_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/periph_bus_sim > sim.log 2>&1
cat sim.log
grep -qx "PASS: all tests" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== sim/periph_bus_tb.sv ====
// Testbench top with stimulus, reference model, monitors and the result line.
`timescale 1ns/1ps
`default_nettype none
`include "periph_bus_config.svh"

module periph_bus_tb;

    import periph_bus_pkg::*;

    localparam int WAIT_LIMIT  = 200;
    localparam int STALL_TIME  = 20;
    localparam int RANDOM_CMDS = 300;

    logic       clk;
    logic       arst_n;
    logic       cmd_valid;
    core_cmd_t  cmd;
    logic       busy;
    data_t      rdata;
    logic       rdata_valid;
    dev_req_t   dev_req [3];
    dev_rsp_t   dev_rsp [3];
    logic [2:0] stall;
    int         dev_errs [3];

    data_t      ref_mem [3][16];
    data_t      exp_q [$];
    core_cmd_t  cur_cmd;
    logic       cur_active;
    int         start_strobes;
    string      test_name;
    integer     seed;
    logic       hung;
    int         strobe_cnt = 0;
    int         data_errs = 0;
    int         strobe_errs = 0;
    int         proto_errs = 0;
    int         timeouts = 0;

    tb_clock_gen u_clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    for (genvar i = 0; i < 3; i++) begin : g_dev
        tb_device_model #(.DEV_ID(i)) u_dev (
            .clk_i     (clk),
            .arst_n_i  (arst_n),
            .stall_i   (stall[i]),
            .req_i     (dev_req[i]),
            .rsp_o     (dev_rsp[i]),
            .err_cnt_o (dev_errs[i])
        );
    end

    periph_bus periph_bus_inst (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .cmd_valid_i   (cmd_valid),
        .cmd_i         (cmd),
        .busy_o        (busy),
        .rdata_o       (rdata),
        .rdata_valid_o (rdata_valid),
        .uart_req_o    (dev_req[SLOT_UART]),
        .spi_req_o     (dev_req[SLOT_SPI]),
        .pwm_req_o     (dev_req[SLOT_PWM]),
        .uart_rsp_i    (dev_rsp[SLOT_UART]),
        .spi_rsp_i     (dev_rsp[SLOT_SPI]),
        .pwm_rsp_i     (dev_rsp[SLOT_PWM])
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic slot_t slot_of(input addr_t addr);
        return addr[`PB_SLOT_LSB +: `PB_SLOT_W];
    endfunction

    function automatic data_t expected_read(input addr_t addr);
        if (slot_of(addr) == SLOT_NONE) return '0;
        return ref_mem[slot_of(addr)][addr[5:2]];
    endfunction

    // Masked bytes merge, unmapped writes vanish.
    function automatic void update_ref(input core_cmd_t c);
        slot_t s;
        s = slot_of(c.addr);
        if (s == SLOT_NONE) return;
        for (int b = 0; b < `PB_MASK_W; b++) begin
            if (c.wmask[b]) ref_mem[s][c.addr[5:2]][b*8 +: 8] = c.wdata[b*8 +: 8];
        end
    endfunction

    function automatic dev_req_t expected_strobe(input core_cmd_t c);
        dev_req_t r;
        r.en    = 1'b1;
        r.we    = c.we;
        r.addr  = c.addr;
        r.wdata = c.wdata;
        r.wmask = c.wmask;
        return r;
    endfunction

    function automatic core_cmd_t make_cmd(input slot_t s, input logic [3:0] idx,
                                           input logic we, input data_t wdata,
                                           input mask_t wmask);
        core_cmd_t c;
        c.addr  = 32'h4000_0000 | (addr_t'(s) << `PB_SLOT_LSB) | (addr_t'(idx) << 2);
        c.wdata = wdata;
        c.wmask = wmask;
        c.we    = we;
        return c;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic check_rdata(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            data_errs++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_dev_req(input string name, input dev_req_t exp, input dev_req_t act);
        if (act !== exp) begin
            strobe_errs++;
            $display("ERROR %s: expected strobe %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            proto_errs++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            proto_errs++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Monitors
    // ~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (rdata_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                data_errs++;
                $display("%s: read data pulse with no read outstanding", test_name);
            end else begin
                check_rdata(test_name, exp_q.pop_front(), rdata);
            end
        end
    end

    // Strobes must hit the decoded device only.
    always @(negedge clk) begin
        for (int s = 0; s < 3; s++) begin
            if (dev_req[s].en === 1'b1) begin
                if (!cur_active || slot_of(cur_cmd.addr) != slot_t'(s)) begin
                    strobe_errs++;
                    $display("%s: device %0d got a strobe it was not addressed by",
                             test_name, s);
                end else begin
                    strobe_cnt++;
                    check_dev_req(test_name, expected_strobe(cur_cmd), dev_req[s]);
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Command sequencing
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic wait_idle();
        int n;
        n = 0;
        while (busy === 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            timeouts++;
            hung = 1'b1;
            $display("%s: busy stayed high for %0d cycles", test_name, WAIT_LIMIT);
        end
    endtask

    task automatic issue_cmd(input string name, input core_cmd_t c);
        test_name = name;
        cur_cmd = c;
        cur_active = 1'b1;
        start_strobes = strobe_cnt;
        if (c.we) begin
            update_ref(c);
        end else begin
            exp_q.push_back(expected_read(c.addr));
        end
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd <= c;
        @(posedge clk);
        cmd_valid <= 1'b0;
        @(negedge clk);
        check_bit({name, " busy after strobe"}, 1'b1, busy);
    endtask

    task automatic finish_cmd();
        int expect_strobes;
        wait_idle();
        if (hung) return;
        expect_strobes = (slot_of(cur_cmd.addr) == SLOT_NONE) ? 0 : 1;
        check_count({test_name, " strobe count"}, expect_strobes, strobe_cnt - start_strobes);
        cur_active = 1'b0;
    endtask

    task automatic run_cmd(input string name, input core_cmd_t c);
        if (hung) return;
        issue_cmd(name, c);
        finish_cmd();
    endtask

    // Device held busy while the command waits.
    task automatic stalled_cmd(input string name, input core_cmd_t c);
        slot_t s;
        s = slot_of(c.addr);
        if (hung) return;
        @(posedge clk);
        stall[s] <= 1'b1;
        issue_cmd(name, c);
        repeat (STALL_TIME) begin
            @(negedge clk);
            check_bit({name, " busy held"}, 1'b1, busy);
        end
        check_count({name, " strobes while stalled"}, 0, strobe_cnt - start_strobes);
        @(posedge clk);
        stall[s] <= 1'b0;
        finish_cmd();
    endtask

    initial begin
        core_cmd_t c;
        int        n;
        mask_t     masks [4];
        cmd_valid = 1'b0;
        cmd = '0;
        stall = '0;
        seed = 32'h9ab7_1e84;
        hung = 1'b0;
        cur_active = 1'b0;
        cur_cmd = '0;
        start_strobes = 0;
        test_name = "reset";
        masks = '{4'b0101, 4'b1000, 4'b0000, 4'b0110};
        for (int s = 0; s < 3; s++) begin
            for (int r = 0; r < 16; r++) ref_mem[s][r] = '0;
        end

        // Idle outputs through reset and shortly after.
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            check_bit("reset busy", 1'b0, busy);
            check_bit("reset rdata_valid", 1'b0, rdata_valid);
            if (arst_n === 1'b1) break;
        end
        if (arst_n !== 1'b1) begin
            timeouts++;
            hung = 1'b1;
            $display("reset was never released");
        end
        repeat (4) begin
            @(negedge clk);
            check_bit("after reset busy", 1'b0, busy);
            check_bit("after reset rdata_valid", 1'b0, rdata_valid);
        end

        for (int s = 0; s < 3; s++) begin
            c = make_cmd(slot_t'(s), 4'(s + 3), 1'b1, $random(seed), 4'hf);
            run_cmd($sformatf("word write slot %0d", s), c);
            c.we = 1'b0;
            run_cmd($sformatf("word read slot %0d", s), c);
        end

        for (int s = 1; s < 3; s++) begin
            c = make_cmd(slot_t'(s), 4'd7, 1'b1, 32'h1122_3344, 4'hf);
            run_cmd("mask base write", c);
            for (int m = 0; m < 4; m++) begin
                c = make_cmd(slot_t'(s), 4'd7, 1'b1, $random(seed), masks[m]);
                run_cmd($sformatf("mask %b write slot %0d", masks[m], s), c);
                c.we = 1'b0;
                run_cmd($sformatf("mask %b read slot %0d", masks[m], s), c);
            end
        end

        c = make_cmd(SLOT_UART, 4'd9, 1'b1, 32'hdead_beef, 4'hf);
        stalled_cmd("stalled write uart", c);
        c.we = 1'b0;
        stalled_cmd("stalled read uart", c);
        c = make_cmd(SLOT_PWM, 4'd2, 1'b1, 32'h0bad_f00d, 4'b1100);
        stalled_cmd("stalled write pwm", c);
        c.we = 1'b0;
        stalled_cmd("stalled read pwm", c);

        c = make_cmd(SLOT_NONE, 4'd5, 1'b1, 32'hffff_ffff, 4'hf);
        run_cmd("unmapped write", c);
        c.we = 1'b0;
        run_cmd("unmapped read", c);

        for (int i = 0; i < RANDOM_CMDS; i++) begin
            c.addr = $random(seed);
            c.addr[1:0] = 2'b00;
            c.wdata = $random(seed);
            c.wmask = 4'($random(seed));
            c.we = 1'($random(seed));
            run_cmd($sformatf("random mix %0d", i), c);
        end

        repeat (2) @(negedge clk);
        if (exp_q.size() != 0) begin
            proto_errs++;
            $display("%0d read data pulses never arrived", exp_q.size());
        end
        $display("errors: data %0d, strobe %0d, protocol %0d, timeout %0d, device %0d",
                 data_errs, strobe_errs, proto_errs, timeouts,
                 dev_errs[0] + dev_errs[1] + dev_errs[2]);
        if (data_errs + strobe_errs + proto_errs + timeouts
            + dev_errs[0] + dev_errs[1] + dev_errs[2] == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// Testbench clock and reset source.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/tb_device_model.sv ====
// Behavioral peripheral with 16 registers, random busy time and random read delay.
`timescale 1ns/1ps
`default_nettype none

module tb_device_model #(
    parameter int unsigned DEV_ID = 0
) (
    input  wire logic                     clk_i,
    input  wire logic                     arst_n_i,
    input  wire logic                     stall_i,
    input  wire periph_bus_pkg::dev_req_t req_i,
    output periph_bus_pkg::dev_rsp_t      rsp_o,
    output int                            err_cnt_o
);

    import periph_bus_pkg::*;

    data_t [15:0] regs;
    logic [1:0]   busy_cnt;
    logic [2:0]   rd_cnt;
    logic [3:0]   rd_idx;
    data_t        rdata_q;
    logic         rvalid_q;
    integer       seed = 32'h9ab7_1e84 ^ DEV_ID;

    function automatic data_t merge_bytes(input data_t old, input data_t wdata,
                                          input mask_t wmask);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return res;
    endfunction

    // Stall input stretches busy for as long as it is held.
    assign rsp_o.busy        = stall_i || (busy_cnt != 2'd0);
    assign rsp_o.rdata       = rdata_q;
    assign rsp_o.rdata_valid = rvalid_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs      <= '0;
            busy_cnt  <= '0;
            rd_cnt    <= '0;
            rd_idx    <= '0;
            rdata_q   <= '0;
            rvalid_q  <= 1'b0;
            err_cnt_o <= 0;
        end else begin
            rvalid_q <= 1'b0;
            if (busy_cnt != 2'd0) begin
                busy_cnt <= busy_cnt - 2'd1;
            end
            if (rd_cnt != 3'd0) begin
                rd_cnt <= rd_cnt - 3'd1;
                if (rd_cnt == 3'd1) begin
                    rvalid_q <= 1'b1;
                    rdata_q  <= regs[rd_idx];
                end
            end
            if (req_i.en) begin
                if (rsp_o.busy) begin
                    $display("device %0d got a strobe while it was busy", DEV_ID);
                    err_cnt_o <= err_cnt_o + 1;
                end
                busy_cnt <= 2'($random(seed));
                if (req_i.we) begin
                    regs[req_i.addr[5:2]] <= merge_bytes(regs[req_i.addr[5:2]], req_i.wdata,
                                                         req_i.wmask);
                end else begin
                    rd_idx <= req_i.addr[5:2];
                    rd_cnt <= {1'b0, 2'($random(seed))} + 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/periph_bus.sv ====
// Peripheral bus top level with the master, the decoder and the UART/SPI/PWM slave adapters.
`timescale 1ns/1ps
`default_nettype none

module periph_bus (
    input  wire logic                      clk_i,
    input  wire logic                      arst_n_i,

    // Core
    input  wire logic                      cmd_valid_i,
    input  wire periph_bus_pkg::core_cmd_t cmd_i,
    output logic                           busy_o,
    output periph_bus_pkg::data_t          rdata_o,
    output logic                           rdata_valid_o,

    // Devices
    output periph_bus_pkg::dev_req_t       uart_req_o,
    output periph_bus_pkg::dev_req_t       spi_req_o,
    output periph_bus_pkg::dev_req_t       pwm_req_o,
    input  wire periph_bus_pkg::dev_rsp_t  uart_rsp_i,
    input  wire periph_bus_pkg::dev_rsp_t  spi_rsp_i,
    input  wire periph_bus_pkg::dev_rsp_t  pwm_rsp_i
);

    import periph_bus_pkg::*;

    wb_req_t    wb_req;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_ack;
    data_t      wb_rdata;
    slot_sel_t  slave_sel;
    logic [2:0] slave_ack;
    data_t [2:0] slave_rdata;

    wb_master u_master (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_i         (cmd_i),
        .busy_o        (busy_o),
        .rdata_o       (rdata_o),
        .rdata_valid_o (rdata_valid_o),
        .wb_req_o      (wb_req),
        .cyc_o         (wb_cyc),
        .stb_o         (wb_stb),
        .ack_i         (wb_ack),
        .wb_rdata_i    (wb_rdata)
    );

    wb_decoder u_decoder (
        .addr_i        (wb_req.addr),
        .cyc_i         (wb_cyc),
        .stb_i         (wb_stb),
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .slave_sel_o   (slave_sel),
        .slave_ack_i   (slave_ack),
        .slave_rdata_i (slave_rdata),
        .ack_o         (wb_ack),
        .rdata_o       (wb_rdata)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Slave adapters
    // ~~~~~~~~~~~~~~~~~~~~
    wb_slave u_slave_uart (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .wb_req_i  (wb_req),
        .cyc_i     (wb_cyc),
        .stb_i     (wb_stb),
        .sel_i     (slave_sel[SLOT_UART]),
        .ack_o     (slave_ack[SLOT_UART]),
        .rdata_o   (slave_rdata[SLOT_UART]),
        .dev_req_o (uart_req_o),
        .dev_rsp_i (uart_rsp_i)
    );

    wb_slave u_slave_spi (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .wb_req_i  (wb_req),
        .cyc_i     (wb_cyc),
        .stb_i     (wb_stb),
        .sel_i     (slave_sel[SLOT_SPI]),
        .ack_o     (slave_ack[SLOT_SPI]),
        .rdata_o   (slave_rdata[SLOT_SPI]),
        .dev_req_o (spi_req_o),
        .dev_rsp_i (spi_rsp_i)
    );

    wb_slave u_slave_pwm (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .wb_req_i  (wb_req),
        .cyc_i     (wb_cyc),
        .stb_i     (wb_stb),
        .sel_i     (slave_sel[SLOT_PWM]),
        .ack_o     (slave_ack[SLOT_PWM]),
        .rdata_o   (slave_rdata[SLOT_PWM]),
        .dev_req_o (pwm_req_o),
        .dev_rsp_i (pwm_rsp_i)
    );

endmodule

`default_nettype wire

// ==== verilog/periph_bus_pkg.sv ====
// Bus word types, request/response structs, slot constants and FSM state enums.
`default_nettype none

package periph_bus_pkg;

    `include "periph_bus_config.svh"

    typedef logic [`PB_ADDR_W-1:0] addr_t;
    typedef logic [`PB_DATA_W-1:0] data_t;
    typedef logic [`PB_MASK_W-1:0] mask_t;
    typedef logic [`PB_SLOT_W-1:0] slot_t;
    // One bit per mapped slot.
    typedef logic [`PB_SLOT_NONE-1:0] slot_sel_t;

    localparam int unsigned SLOT_LSB = `PB_SLOT_LSB;
    localparam slot_t SLOT_UART = `PB_SLOT_UART;
    localparam slot_t SLOT_SPI  = `PB_SLOT_SPI;
    localparam slot_t SLOT_PWM  = `PB_SLOT_PWM;
    localparam slot_t SLOT_NONE = `PB_SLOT_NONE;

    // ~~~~~~~~~~~~~~~~~~~~
    // Payloads
    // ~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        mask_t wmask;
        logic  we;
    } core_cmd_t;

    typedef struct packed {
        addr_t addr;
        data_t wdata;
        mask_t wmask;
        logic  we;
    } wb_req_t;

    typedef struct packed {
        logic  en;
        logic  we;
        addr_t addr;
        data_t wdata;
        mask_t wmask;
    } dev_req_t;

    typedef struct packed {
        logic  busy;
        data_t rdata;
        logic  rdata_valid;
    } dev_rsp_t;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_CYCLE,
        MS_DONE
    } master_state_e;

    typedef enum logic [1:0] {
        SS_IDLE,
        SS_WAIT_READY,
        SS_WAIT_DATA,
        SS_ACK
    } slave_state_e;

endpackage

`default_nettype wire

// ==== verilog/wb_decoder.sv ====
// Address decoder with ack/data mux and the unmapped-slot responder.
`timescale 1ns/1ps
`default_nettype none

module wb_decoder (
    input  wire periph_bus_pkg::addr_t       addr_i,
    input  wire logic                        cyc_i,
    input  wire logic                        stb_i,
    input  wire logic                        clk_i,
    input  wire logic                        arst_n_i,
    output periph_bus_pkg::slot_sel_t        slave_sel_o,
    input  wire logic [2:0]                  slave_ack_i,
    input  wire periph_bus_pkg::data_t [2:0] slave_rdata_i,
    output logic                             ack_o,
    output periph_bus_pkg::data_t            rdata_o
);

    import periph_bus_pkg::*;

    slot_t slot;
    logic  none_ack_q;

    assign slot = addr_i[SLOT_LSB +: $bits(slot_t)];

    always_comb begin
        slave_sel_o = '0;
        if (cyc_i && slot != SLOT_NONE) begin
            slave_sel_o[slot] = 1'b1;
        end
    end

    // Unmapped slot acks by itself one cycle after stb.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= cyc_i && stb_i && (slot == SLOT_NONE) && !none_ack_q;
        end
    end

    always_comb begin
        if (slot == SLOT_NONE) begin
            ack_o   = none_ack_q;
            rdata_o = '0;
        end else begin
            ack_o   = slave_ack_i[slot];
            rdata_o = slave_rdata_i[slot];
        end
    end

    // Acks come only from the selected slave.
    a_ack_from_selected : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (slave_ack_i & ~slave_sel_o) == '0
    );

endmodule

`default_nettype wire

// ==== verilog/wb_master.sv ====
// Wishbone master that runs one single-beat cycle per core command.
`timescale 1ns/1ps
`default_nettype none

module wb_master (
    input  wire logic                      clk_i,
    input  wire logic                      arst_n_i,

    // Core command port
    input  wire logic                      cmd_valid_i,
    input  wire periph_bus_pkg::core_cmd_t cmd_i,
    output logic                           busy_o,
    output periph_bus_pkg::data_t          rdata_o,
    output logic                           rdata_valid_o,

    // Wishbone side
    output periph_bus_pkg::wb_req_t        wb_req_o,
    output logic                           cyc_o,
    output logic                           stb_o,
    input  wire logic                      ack_i,
    input  wire periph_bus_pkg::data_t     wb_rdata_i
);

    import periph_bus_pkg::*;

    master_state_e state_q;
    master_state_e state_d;
    logic          accept;

    // A command is taken in idle or in the done cycle.
    assign accept = cmd_valid_i && !busy_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            MS_IDLE: begin
                if (accept) state_d = MS_CYCLE;
            end
            MS_CYCLE: begin
                if (ack_i) state_d = MS_DONE;
            end
            MS_DONE: begin
                state_d = accept ? MS_CYCLE : MS_IDLE;
            end
            default: state_d = MS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= MS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Request and read data
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (accept) begin
            wb_req_o.addr  <= cmd_i.addr;
            wb_req_o.wdata <= cmd_i.wdata;
            wb_req_o.wmask <= cmd_i.wmask;
            wb_req_o.we    <= cmd_i.we;
        end
        if (state_q == MS_CYCLE && ack_i && !wb_req_o.we) begin
            rdata_o <= wb_rdata_i;
        end
    end

    // Cyc and stb are held for the whole cycle.
    assign cyc_o  = (state_q == MS_CYCLE);
    assign stb_o  = (state_q == MS_CYCLE);
    assign busy_o = (state_q == MS_CYCLE);

    // Request stays in place through the done cycle.
    assign rdata_valid_o = (state_q == MS_DONE) && !wb_req_o.we;

    // ~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~
    a_no_cmd_while_busy : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        cmd_valid_i |-> !busy_o
    );

    a_ack_within_cycle : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        ack_i |-> cyc_o
    );

endmodule

`default_nettype wire

// ==== verilog/wb_slave.sv ====
// Wishbone slave adapter that turns a bus cycle into a device strobe.
`timescale 1ns/1ps
`default_nettype none

module wb_slave (
    input  wire logic                     clk_i,
    input  wire logic                     arst_n_i,

    // Wishbone side
    input  wire periph_bus_pkg::wb_req_t  wb_req_i,
    input  wire logic                     cyc_i,
    input  wire logic                     stb_i,
    input  wire logic                     sel_i,
    output logic                          ack_o,
    output periph_bus_pkg::data_t         rdata_o,

    // Device side
    output periph_bus_pkg::dev_req_t      dev_req_o,
    input  wire periph_bus_pkg::dev_rsp_t dev_rsp_i
);

    import periph_bus_pkg::*;

    slave_state_e state_q;
    slave_state_e state_d;
    logic         dev_en;

    // Strobe only in a cycle where the device is free.
    assign dev_en = (state_q == SS_WAIT_READY) && !dev_rsp_i.busy;

    always_comb begin
        state_d = state_q;
        case (state_q)
            SS_IDLE: begin
                if (sel_i && cyc_i && stb_i) state_d = SS_WAIT_READY;
            end
            SS_WAIT_READY: begin
                if (dev_en) state_d = wb_req_i.we ? SS_ACK : SS_WAIT_DATA;
            end
            SS_WAIT_DATA: begin
                if (dev_rsp_i.rdata_valid) state_d = SS_ACK;
            end
            SS_ACK: begin
                state_d = SS_IDLE;
            end
            default: state_d = SS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= SS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == SS_WAIT_DATA && dev_rsp_i.rdata_valid) begin
            rdata_o <= dev_rsp_i.rdata;
        end
    end

    assign ack_o = (state_q == SS_ACK);

    // Master holds the request until ack.
    assign dev_req_o.en    = dev_en;
    assign dev_req_o.we    = wb_req_i.we;
    assign dev_req_o.addr  = wb_req_i.addr;
    assign dev_req_o.wdata = wb_req_i.wdata;
    assign dev_req_o.wmask = wb_req_i.wmask;

    // Strobe only inside a selected bus cycle.
    a_en_in_cycle : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        dev_req_o.en |-> sel_i && cyc_i && stb_i
    );

endmodule

`default_nettype wire
